// File: hdl/bru_settings.svh
`ifndef BRU_SETTINGS_SVH
`define BRU_SETTINGS_SVH

// ========================================
// datapath widths
// ========================================

// data and pc width
`define BRU_XLEN 64

// rename bits per architectural register
`define BRU_RB 2

// ========================================
// queue depths
// ========================================

`define BRU_ISSUE_DEPTH 4
`define BRU_RESOLVE_DEPTH 4

`endif

// File: hdl/bru_pkg.sv
`include "bru_settings.svh"

package bru_pkg;

	// ========================================
	// branch and jump operations
	// ========================================

	typedef enum logic [2:0] {
		BRU_JAL  = 3'd0,
		BRU_JALR = 3'd1,
		BRU_BEQ  = 3'd2,
		BRU_BNE  = 3'd3,
		BRU_BLT  = 3'd4,
		BRU_BGE  = 3'd5,
		BRU_BLTU = 3'd6,
		BRU_BGEU = 3'd7
	} bru_op_e;

	// physical register, {arch number, rename bits}
	typedef logic [5+`BRU_RB-1:0] bru_preg_t;

	// ========================================
	// payloads
	// ========================================

	// dispatch record, as written into the issue queue
	typedef struct packed {
		bru_op_e               op;
		logic                  is_rvc;
		logic [`BRU_XLEN-1:0] pc;
		logic [`BRU_XLEN-1:0] imm;
		bru_preg_t             rd;
		bru_preg_t             rs1;
		bru_preg_t             rs2;
		logic                  pred_taken;
	} bru_issue_info_t;

	// registered execute parameter
	// operand indices first, pc and imm last
	typedef struct packed {
		bru_op_e               op;
		logic                  is_rvc;
		logic                  pred_taken;
		bru_preg_t             rs1;
		bru_preg_t             rs2;
		bru_preg_t             rd;
		logic [`BRU_XLEN-1:0] pc;
		logic [`BRU_XLEN-1:0] imm;
	} bru_exeparam_t;

	// resolution record for the commit side
	typedef struct packed {
		logic [`BRU_XLEN-1:0] pc;
		logic [`BRU_XLEN-1:0] target;
		logic                  taken;
		logic                  mispredict;
	} bru_resolve_t;

endpackage

// File: hdl/bru_fifo.sv
`timescale 1ns/100ps

module bru_fifo #(
	parameter int DEPTH = 4,
	parameter type payload_t = logic
) (
	input  logic     CLK,
	input  logic     rst_n,
	input  logic     flush,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output payload_t head,
	output logic     empty,
	output logic     full,
	output logic     almost_full
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	// entry storage
	payload_t      mem [DEPTH];
	logic [AW-1:0] rd_ptr;
	logic [AW-1:0] wr_ptr;
	logic [CW-1:0] count;
	logic          do_push;
	logic          do_pop;

	// wraps at DEPTH for any depth
	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
		return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// guarded strobes
	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	always_ff @(posedge CLK) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// flush drops every entry
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (!do_push && do_pop) begin
				count <= count - 1'b1;
			end
		end
	end

	assign head  = mem[rd_ptr];
	assign empty = (count == '0);
	assign full  = (count == CW'(DEPTH));
	// one entry early to leave room for an in-flight push
	assign almost_full = (count >= CW'(DEPTH - 1));

endmodule

// File: hdl/bru_wb_log.sv
`timescale 1ns/100ps
`include "bru_settings.svh"

module bru_wb_log (
	input  logic                  CLK,
	input  logic                  rst_n,
	input  logic                  alloc_valid,
	input  bru_pkg::bru_preg_t    alloc_preg,
	input  logic                  wb_valid,
	input  bru_pkg::bru_preg_t    wb_preg,
	input  logic [`BRU_XLEN-1:0] wb_data,
	input  logic                  link_valid,
	input  bru_pkg::bru_preg_t    link_preg,
	input  logic [`BRU_XLEN-1:0] link_data,
	input  bru_pkg::bru_preg_t    rs1_preg,
	input  bru_pkg::bru_preg_t    rs2_preg,
	output logic                  rs1_ready,
	output logic                  rs2_ready,
	output logic [`BRU_XLEN-1:0] rs1_data,
	output logic [`BRU_XLEN-1:0] rs2_data,
	input  bru_pkg::bru_preg_t    issue_rs1_preg,
	input  bru_pkg::bru_preg_t    issue_rs2_preg,
	output logic [`BRU_XLEN-1:0] issue_rs1_data,
	output logic [`BRU_XLEN-1:0] issue_rs2_data
);

	import bru_pkg::*;

	// 32 arch regs times 2^rb rename slots
	localparam int NPREG = 32 * (1 << `BRU_RB);

	logic [NPREG-1:0]          ready_q;
	logic [`BRU_XLEN-1:0]     value_q [NPREG];

	// arch number zero is x0 in every slot
	function automatic logic is_x0(input bru_preg_t preg);
		return (preg[`BRU_RB +: 5] == 5'd0);
	endfunction

	// ========================================
	// ready bits
	// ========================================

	// set on writeback, cleared on allocation
	// allocation of a fresh slot wins
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			ready_q <= '1;
		end else begin
			if (wb_valid) begin
				ready_q[wb_preg] <= 1'b1;
			end
			if (link_valid) begin
				ready_q[link_preg] <= 1'b1;
			end
			if (alloc_valid && !is_x0(alloc_preg)) begin
				ready_q[alloc_preg] <= 1'b0;
			end
		end
	end

	// value store, link port last
	always_ff @(posedge CLK) begin
		if (wb_valid) begin
			value_q[wb_preg] <= wb_data;
		end
		if (link_valid) begin
			value_q[link_preg] <= link_data;
		end
	end

	// ========================================
	// read ports
	// ========================================

	assign rs1_ready = ready_q[rs1_preg] | is_x0(rs1_preg);
	assign rs2_ready = ready_q[rs2_preg] | is_x0(rs2_preg);
	assign rs1_data  = is_x0(rs1_preg) ? '0 : value_q[rs1_preg];
	assign rs2_data  = is_x0(rs2_preg) ? '0 : value_q[rs2_preg];

	// operands of the issued instruction
	assign issue_rs1_data = is_x0(issue_rs1_preg) ? '0 : value_q[issue_rs1_preg];
	assign issue_rs2_data = is_x0(issue_rs2_preg) ? '0 : value_q[issue_rs2_preg];

endmodule

// File: hdl/bru_issue.sv
`timescale 1ns/100ps

module bru_issue (
	input  logic                      CLK,
	input  logic                      rst_n,
	input  logic                      flush,
	input  logic                      fifo_empty,
	input  bru_pkg::bru_issue_info_t  issue_info,
	output logic                      fifo_pop,
	output bru_pkg::bru_preg_t        rs1_preg,
	output bru_pkg::bru_preg_t        rs2_preg,
	input  logic                      rs1_ready,
	input  logic                      rs2_ready,
	input  logic                      ilp_ready,
	input  logic                      exeparam_ready,
	output logic                      exeparam_valid,
	output bru_pkg::bru_exeparam_t    exeparam
);

	import bru_pkg::*;

	logic need_rs1;
	logic need_rs2;
	logic is_branch;
	logic clear_raw;
	logic issue_go;

	// ========================================
	// operand needs per op
	// ========================================

	always_comb begin
		need_rs1  = 1'b0;
		need_rs2  = 1'b0;
		is_branch = 1'b0;
		unique case (issue_info.op)
			// jal has no source
			BRU_JAL: begin
			end
			BRU_JALR: begin
				need_rs1 = 1'b1;
			end
			default: begin
				// conditional branches
				need_rs1  = 1'b1;
				need_rs2  = 1'b1;
				is_branch = 1'b1;
			end
		endcase
	end

	// readiness lookup in the log
	assign rs1_preg = issue_info.rs1;
	assign rs2_preg = issue_info.rs2;

	// raw hazard cleared, branches also wait for in-order permission
	assign clear_raw = ~fifo_empty
		& (~need_rs1 | rs1_ready)
		& (~need_rs2 | rs2_ready)
		& (~is_branch | ilp_ready);

	// single decision for pop and capture
	assign issue_go = clear_raw & exeparam_ready & ~flush;
	assign fifo_pop = issue_go;

	// ========================================
	// execute parameter register
	// ========================================

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			exeparam_valid <= 1'b0;
		end else begin
			exeparam_valid <= issue_go;
		end
	end

	// payload holds when idle
	always_ff @(posedge CLK) begin
		if (issue_go) begin
			exeparam.op         <= issue_info.op;
			exeparam.is_rvc     <= issue_info.is_rvc;
			exeparam.pred_taken <= issue_info.pred_taken;
			exeparam.rs1        <= issue_info.rs1;
			exeparam.rs2        <= issue_info.rs2;
			exeparam.rd         <= issue_info.rd;
			exeparam.pc         <= issue_info.pc;
			exeparam.imm        <= issue_info.imm;
		end
	end

endmodule

// File: hdl/bru_execute.sv
`timescale 1ns/100ps
`include "bru_settings.svh"

module bru_execute (
	input  logic                    CLK,
	input  logic                    rst_n,
	input  logic                    flush,
	input  logic                    exeparam_valid,
	input  bru_pkg::bru_exeparam_t  exeparam,
	output bru_pkg::bru_preg_t      rs1_preg,
	output bru_pkg::bru_preg_t      rs2_preg,
	input  logic [`BRU_XLEN-1:0]   rs1_data,
	input  logic [`BRU_XLEN-1:0]   rs2_data,
	input  logic                    res_almost_full,
	output logic                    exeparam_ready,
	output logic                    res_push,
	output bru_pkg::bru_resolve_t   res_data,
	output logic                    link_valid,
	output bru_pkg::bru_preg_t      link_preg,
	output logic [`BRU_XLEN-1:0]   link_data
);

	import bru_pkg::*;

	logic                  eq;
	logic                  lt;
	logic                  ltu;
	logic                  taken;
	logic                  is_jump;
	logic                  rd_nonzero;
	logic                  pend_q;
	logic [`BRU_XLEN-1:0] seq_pc;
	logic [`BRU_XLEN-1:0] jump_target;

	// operand read from the log
	assign rs1_preg = exeparam.rs1;
	assign rs2_preg = exeparam.rs2;

	// room for this and the in-flight record
	assign exeparam_ready = ~res_almost_full;

	// ========================================
	// compare
	// ========================================

	assign eq  = (rs1_data == rs2_data);
	assign lt  = ($signed(rs1_data) < $signed(rs2_data));
	assign ltu = (rs1_data < rs2_data);

	always_comb begin
		unique case (exeparam.op)
			BRU_BEQ:  taken = eq;
			BRU_BNE:  taken = ~eq;
			BRU_BLT:  taken = lt;
			BRU_BGE:  taken = ~lt;
			BRU_BLTU: taken = ltu;
			BRU_BGEU: taken = ~ltu;
			// jal, jalr always taken
			default:  taken = 1'b1;
		endcase
	end

	// ========================================
	// target, fall-through, link
	// ========================================

	// compressed instrs advance by 2
	assign seq_pc = exeparam.pc + (exeparam.is_rvc ? `BRU_XLEN'd2 : `BRU_XLEN'd4);

	// jalr clears bit 0
	assign jump_target = (exeparam.op == BRU_JALR)
		? ((rs1_data + exeparam.imm) & ~`BRU_XLEN'd1)
		: (exeparam.pc + exeparam.imm);

	assign is_jump    = (exeparam.op == BRU_JAL) | (exeparam.op == BRU_JALR);
	assign rd_nonzero = (exeparam.rd[`BRU_RB +: 5] != 5'd0);

	// valid param becomes a write at the end of this cycle
	// unless flush drops it
	always_comb begin
		pend_q = exeparam_valid & ~flush;
	end

	assign res_push            = pend_q;
	assign res_data.pc         = exeparam.pc;
	assign res_data.target     = taken ? jump_target : seq_pc;
	assign res_data.taken      = taken;
	assign res_data.mispredict = taken ^ exeparam.pred_taken;

	// link writeback for jumps with a real rd
	assign link_valid = pend_q & is_jump & rd_nonzero;
	assign link_preg  = exeparam.rd;
	assign link_data  = seq_pc;

endmodule

// File: hdl/bru_top.sv
`timescale 1ns/100ps
`include "bru_settings.svh"

module bru_top (
	input  logic                      CLK,
	input  logic                      rst_n,
	input  logic                      flush,
	input  logic                      disp_push,
	input  bru_pkg::bru_issue_info_t  disp_info,
	output logic                      disp_full,
	input  logic                      wb_valid,
	input  bru_pkg::bru_preg_t        wb_preg,
	input  logic [`BRU_XLEN-1:0]     wb_data,
	input  logic                      ilp_ready,
	input  logic                      res_pop,
	output logic                      res_empty,
	output bru_pkg::bru_resolve_t     res_data,
	output logic                      link_valid,
	output bru_pkg::bru_preg_t        link_preg,
	output logic [`BRU_XLEN-1:0]     link_data
);

	import bru_pkg::*;

	// issue queue side
	logic            iq_empty;
	logic            iq_pop;
	bru_issue_info_t iq_head;
	logic            alloc_valid;

	// operand lookups
	bru_preg_t            iss_rs1_preg;
	bru_preg_t            iss_rs2_preg;
	logic                 iss_rs1_ready;
	logic                 iss_rs2_ready;
	bru_preg_t            exe_rs1_preg;
	bru_preg_t            exe_rs2_preg;
	logic [`BRU_XLEN-1:0] exe_rs1_data;
	logic [`BRU_XLEN-1:0] exe_rs2_data;

	// issue to execute
	logic          exeparam_valid;
	logic          exeparam_ready;
	bru_exeparam_t exeparam;

	// execute to resolution queue
	logic         res_push;
	bru_resolve_t res_push_data;
	logic         res_almost_full;

	// ========================================
	// input side
	// ========================================

	// only jumps write a destination, dropped pushes allocate nothing
	assign alloc_valid = disp_push & ~flush & ~disp_full
		& ((disp_info.op == BRU_JAL) | (disp_info.op == BRU_JALR));

	bru_fifo #(
		.DEPTH     (`BRU_ISSUE_DEPTH),
		.payload_t (bru_issue_info_t)
	) u_issue_fifo (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.flush       (flush),
		.push        (disp_push),
		.push_data   (disp_info),
		.pop         (iq_pop),
		.head        (iq_head),
		.empty       (iq_empty),
		.full        (disp_full),
		.almost_full ()
	);

	bru_wb_log u_wb_log (
		.CLK            (CLK),
		.rst_n          (rst_n),
		.alloc_valid    (alloc_valid),
		.alloc_preg     (disp_info.rd),
		.wb_valid       (wb_valid),
		.wb_preg        (wb_preg),
		.wb_data        (wb_data),
		.link_valid     (link_valid),
		.link_preg      (link_preg),
		.link_data      (link_data),
		.rs1_preg       (iss_rs1_preg),
		.rs2_preg       (iss_rs2_preg),
		.rs1_ready      (iss_rs1_ready),
		.rs2_ready      (iss_rs2_ready),
		.rs1_data       (),
		.rs2_data       (),
		.issue_rs1_preg (exe_rs1_preg),
		.issue_rs2_preg (exe_rs2_preg),
		.issue_rs1_data (exe_rs1_data),
		.issue_rs2_data (exe_rs2_data)
	);

	// ========================================
	// issue and execute
	// ========================================

	bru_issue u_issue (
		.CLK            (CLK),
		.rst_n          (rst_n),
		.flush          (flush),
		.fifo_empty     (iq_empty),
		.issue_info     (iq_head),
		.fifo_pop       (iq_pop),
		.rs1_preg       (iss_rs1_preg),
		.rs2_preg       (iss_rs2_preg),
		.rs1_ready      (iss_rs1_ready),
		.rs2_ready      (iss_rs2_ready),
		.ilp_ready      (ilp_ready),
		.exeparam_ready (exeparam_ready),
		.exeparam_valid (exeparam_valid),
		.exeparam       (exeparam)
	);

	bru_execute u_execute (
		.CLK             (CLK),
		.rst_n           (rst_n),
		.flush           (flush),
		.exeparam_valid  (exeparam_valid),
		.exeparam        (exeparam),
		.rs1_preg        (exe_rs1_preg),
		.rs2_preg        (exe_rs2_preg),
		.rs1_data        (exe_rs1_data),
		.rs2_data        (exe_rs2_data),
		.res_almost_full (res_almost_full),
		.exeparam_ready  (exeparam_ready),
		.res_push        (res_push),
		.res_data        (res_push_data),
		.link_valid      (link_valid),
		.link_preg       (link_preg),
		.link_data       (link_data)
	);

	// ========================================
	// output side
	// ========================================

	bru_fifo #(
		.DEPTH     (`BRU_RESOLVE_DEPTH),
		.payload_t (bru_resolve_t)
	) u_resolve_fifo (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.flush       (flush),
		.push        (res_push),
		.push_data   (res_push_data),
		.pop         (res_pop),
		.head        (res_data),
		.empty       (res_empty),
		.full        (),
		.almost_full (res_almost_full)
	);

endmodule

// File: tests/bru_assertions.sv
`timescale 1ns/100ps

module bru_assertions (
	input logic CLK,
	input logic rst_n,
	input logic flush,
	input logic pop,
	input logic empty,
	input logic push,
	input logic full,
	input logic exeparam_valid
);

	// queue strobes stay inside the occupancy
	pop_not_empty: assert property (@(posedge CLK) disable iff (!rst_n) !(pop && empty))
		else $error("pop seen while the queue is empty");

	push_not_full: assert property (@(posedge CLK) disable iff (!rst_n) !(push && full))
		else $error("push seen while the queue is full");

	// flush kills the next execute parameter
	no_valid_after_flush: assert property (@(posedge CLK) disable iff (!rst_n)
		flush |=> !exeparam_valid)
		else $error("execute parameter valid right after a flush");

endmodule

// one copy per queue, one on the issue stage
bind bru_fifo bru_assertions u_fifo_checks (
	.CLK(CLK), .rst_n(rst_n), .flush(flush), .pop(pop), .empty(empty),
	.push(push), .full(full), .exeparam_valid(1'b0)
);

bind bru_issue bru_assertions u_issue_checks (
	.CLK(CLK), .rst_n(rst_n), .flush(flush), .pop(fifo_pop), .empty(fifo_empty),
	.push(1'b0), .full(1'b0), .exeparam_valid(exeparam_valid)
);

// File: tests/bru_checker.sv
`timescale 1ns/100ps
`include "bru_settings.svh"

module bru_checker (
	input  logic                    CLK,
	input  logic                    rst_n,
	input  logic                    flush,
	input  logic                    res_pop,
	input  logic                    res_empty,
	input  bru_pkg::bru_resolve_t   res_data,
	input  logic                    link_valid,
	input  bru_pkg::bru_preg_t      link_preg,
	input  logic [`BRU_XLEN-1:0]   link_data,
	input  logic                    exp_res_valid,
	input  bru_pkg::bru_resolve_t   exp_res,
	input  logic                    exp_link_valid,
	input  bru_pkg::bru_preg_t      exp_link_preg,
	input  logic [`BRU_XLEN-1:0]   exp_link_data,
	output int                      res_pending,
	output int                      link_pending,
	output int                      mismatches,
	output int                      other_errors
);

	import bru_pkg::*;

	// expected records in dispatch order
	bru_resolve_t         res_q [$];
	bru_preg_t            lpreg_q [$];
	logic [`BRU_XLEN-1:0] ldata_q [$];

	initial begin
		res_pending  = 0;
		link_pending = 0;
		mismatches   = 0;
		other_errors = 0;
	end

	always @(posedge CLK) begin : check_edge
		bru_resolve_t         want;
		bru_preg_t            want_preg;
		logic [`BRU_XLEN-1:0] want_data;
		if (rst_n && flush) begin
			// everything in flight is discarded
			res_q.delete();
			lpreg_q.delete();
			ldata_q.delete();
		end else if (rst_n) begin
			if (exp_res_valid) begin
				res_q.push_back(exp_res);
			end
			if (exp_link_valid) begin
				lpreg_q.push_back(exp_link_preg);
				ldata_q.push_back(exp_link_data);
			end
			// commit side pop
			if (res_pop && !res_empty) begin
				if (res_q.size() == 0) begin
					other_errors++;
					$display("resolution popped at %0t with no record expected", $time);
				end else begin
					want = res_q.pop_front();
					if (res_data !== want) begin
						mismatches++;
						$display("** Error at %0t: pc %h got target %h taken %b misp %b, want %h %b %b",
							$time, want.pc, res_data.target, res_data.taken,
							res_data.mispredict, want.target, want.taken, want.mispredict);
					end
				end
			end
			// link writeback into the log
			if (link_valid) begin
				if (lpreg_q.size() == 0) begin
					other_errors++;
					$display("link write at %0t with no link expected", $time);
				end else begin
					want_preg = lpreg_q.pop_front();
					want_data = ldata_q.pop_front();
					if (link_preg !== want_preg || link_data !== want_data) begin
						mismatches++;
						$display("** Error at %0t: link got preg %0d data %h, want preg %0d data %h",
							$time, link_preg, link_data, want_preg, want_data);
					end
				end
			end
		end
		res_pending  = res_q.size();
		link_pending = lpreg_q.size();
	end

endmodule

// File: tests/bru_tb.sv
`timescale 1ns/100ps
`include "bru_settings.svh"

module bru_tb;

	import bru_pkg::*;

	localparam int TMO = 500;

	logic                 CLK = 1'b0;
	logic                 rst_n;
	logic                 flush;
	logic                 disp_push;
	bru_issue_info_t      disp_info;
	logic                 disp_full;
	logic                 wb_valid;
	bru_preg_t            wb_preg;
	logic [`BRU_XLEN-1:0] wb_data;
	logic                 ilp_ready;
	logic                 res_pop;
	logic                 res_empty;
	bru_resolve_t         res_data;
	logic                 link_valid;
	bru_preg_t            link_preg;
	logic [`BRU_XLEN-1:0] link_data;

	// expectations toward the checker
	logic                 exp_res_valid;
	bru_resolve_t         exp_res;
	logic                 exp_link_valid;
	bru_preg_t            exp_link_preg;
	logic [`BRU_XLEN-1:0] exp_link_data;
	int                   res_pending;
	int                   link_pending;
	int                   mismatches;
	int                   other_errors;

	// ========================================
	// reference state
	// ========================================

	logic [`BRU_XLEN-1:0] model_reg [128];
	logic                 busy [128];
	int                   refcnt [128];
	logic [15:0]          src_q [$];
	logic                 pop_on;
	int                   ilp_mode;
	int                   tb_errors;
	int                   timeouts;
	bru_preg_t            last_rd;
	int                   n;

	always #50 CLK = ~CLK;

	bru_top uut (
		.CLK(CLK), .rst_n(rst_n), .flush(flush), .disp_push(disp_push),
		.disp_info(disp_info), .disp_full(disp_full), .wb_valid(wb_valid),
		.wb_preg(wb_preg), .wb_data(wb_data), .ilp_ready(ilp_ready),
		.res_pop(res_pop), .res_empty(res_empty), .res_data(res_data),
		.link_valid(link_valid), .link_preg(link_preg), .link_data(link_data)
	);

	bru_checker u_checker (
		.CLK(CLK), .rst_n(rst_n), .flush(flush), .res_pop(res_pop),
		.res_empty(res_empty), .res_data(res_data), .link_valid(link_valid),
		.link_preg(link_preg), .link_data(link_data), .exp_res_valid(exp_res_valid),
		.exp_res(exp_res), .exp_link_valid(exp_link_valid),
		.exp_link_preg(exp_link_preg), .exp_link_data(exp_link_data),
		.res_pending(res_pending), .link_pending(link_pending),
		.mismatches(mismatches), .other_errors(other_errors)
	);

	// resolution rules for branches and jumps
	function automatic bru_resolve_t model_resolve(input bru_issue_info_t in,
		input logic [`BRU_XLEN-1:0] a, input logic [`BRU_XLEN-1:0] b);
		bru_resolve_t         r;
		logic                 tk;
		logic [`BRU_XLEN-1:0] jt;
		case (in.op)
			BRU_BEQ:  tk = (a == b);
			BRU_BNE:  tk = (a != b);
			BRU_BLT:  tk = ($signed(a) < $signed(b));
			BRU_BGE:  tk = ($signed(a) >= $signed(b));
			BRU_BLTU: tk = (a < b);
			BRU_BGEU: tk = (a >= b);
			default:  tk = 1'b1;
		endcase
		jt = (in.op == BRU_JALR) ? a + in.imm : in.pc + in.imm;
		if (in.op == BRU_JALR) begin
			jt[0] = 1'b0;
		end
		r.pc         = in.pc;
		r.taken      = tk;
		r.target     = tk ? jt : in.pc + (in.is_rvc ? 64'd2 : 64'd4);
		r.mispredict = (tk != in.pred_taken);
		return r;
	endfunction

	// sources no longer pin their pregs once resolved
	function automatic void release_srcs(input logic [15:0] s);
		if (s[15]) begin
			refcnt[s[13:7]]--;
		end
		if (s[14]) begin
			refcnt[s[6:0]]--;
		end
	endfunction

	// free slot not read by anything outstanding
	// some jumps get x0 on purpose, x0 also when no slot is free
	function automatic bru_preg_t pick_rd();
		bru_preg_t p;
		if ($urandom_range(7) == 0) begin
			return 7'($urandom_range(3));
		end
		for (int i = 0; i < 16; i++) begin
			p = 7'($urandom_range(127, 4));
			if (!busy[p] && refcnt[p] == 0) begin
				return p;
			end
		end
		return 7'($urandom_range(3));
	endfunction

	// one clock with inputs driven 1 ns after the edge
	task automatic tick();
		logic [15:0] s;
		@(negedge CLK);
		if (link_valid) begin
			busy[link_preg] = 1'b0;
		end
		@(posedge CLK);
		#1;
		disp_push      = 1'b0;
		wb_valid       = 1'b0;
		flush          = 1'b0;
		exp_res_valid  = 1'b0;
		exp_link_valid = 1'b0;
		res_pop        = 1'b0;
		if (pop_on && !res_empty && $urandom_range(3) != 0) begin
			res_pop = 1'b1;
			if (src_q.size() > 0) begin
				s = src_q.pop_front();
				release_srcs(s);
			end
		end
		case (ilp_mode)
			0:       ilp_ready = 1'b1;
			1:       ilp_ready = 1'b0;
			default: ilp_ready = 1'($urandom_range(1));
		endcase
	endtask

	task automatic write_back(input bru_preg_t p);
		wb_valid     = 1'b1;
		wb_preg      = p;
		wb_data      = {$urandom, $urandom};
		model_reg[p] = wb_data;
		busy[p]      = 1'b0;
		tick();
	endtask

	// src1 below zero picks a random first source
	task automatic dispatch(input bru_op_e op, input int src1);
		bru_issue_info_t      info;
		logic [31:0]          r;
		logic                 need1;
		logic                 need2;
		int                   waited;
		logic [`BRU_XLEN-1:0] link;
		waited = 0;
		while (disp_full && waited < TMO) begin
			tick();
			waited++;
		end
		if (disp_full) begin
			timeouts++;
			$display("timed out waiting for room in the issue queue");
		end else begin
			r               = $urandom;
			info.op         = op;
			info.is_rvc     = r[31];
			info.pred_taken = r[30];
			info.pc         = {$urandom, $urandom} & ~64'h1;
			info.imm        = {{52{r[11]}}, r[11:0]};
			// only jalr sees an odd offset
			if (op != BRU_JALR) begin
				info.imm[0] = 1'b0;
			end
			info.rs1 = (src1 < 0) ? 7'($urandom_range(127)) : 7'(src1);
			info.rs2 = (r[29:28] == 2'd0) ? info.rs1 : 7'($urandom_range(127));
			need1    = (op != BRU_JAL);
			need2    = (op != BRU_JAL) && (op != BRU_JALR);
			if (need1) begin
				refcnt[info.rs1]++;
			end
			if (need2) begin
				refcnt[info.rs2]++;
			end
			src_q.push_back({need1, need2, info.rs1, info.rs2});
			info.rd = need2 ? 7'($urandom_range(127)) : pick_rd();
			exp_res       = model_resolve(info, model_reg[info.rs1], model_reg[info.rs2]);
			exp_res_valid = 1'b1;
			link          = info.pc + (info.is_rvc ? 64'd2 : 64'd4);
			if (!need2 && info.rd[6:2] != 5'd0) begin
				model_reg[info.rd] = link;
				busy[info.rd]      = 1'b1;
				exp_link_valid     = 1'b1;
				exp_link_preg      = info.rd;
				exp_link_data      = link;
			end
			last_rd   = info.rd;
			disp_info = info;
			disp_push = 1'b1;
			tick();
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		pop_on = 1'b1;
		while ((res_pending != 0 || link_pending != 0 || !res_empty) && waited < TMO) begin
			tick();
			waited++;
		end
		if (res_pending != 0 || link_pending != 0 || !res_empty) begin
			timeouts++;
			$display("timed out waiting for outstanding resolutions to drain");
		end
	endtask

	// ========================================
	// stimulus
	// ========================================

	initial begin
		void'($urandom(5152));
		rst_n          = 1'b0;
		flush          = 1'b0;
		disp_push      = 1'b0;
		disp_info      = '0;
		wb_valid       = 1'b0;
		wb_preg        = '0;
		wb_data        = '0;
		ilp_ready      = 1'b0;
		res_pop        = 1'b0;
		exp_res_valid  = 1'b0;
		exp_res        = '0;
		exp_link_valid = 1'b0;
		exp_link_preg  = '0;
		exp_link_data  = '0;
		pop_on         = 1'b0;
		ilp_mode       = 0;
		tb_errors      = 0;
		timeouts       = 0;
		last_rd        = '0;
		for (int p = 0; p < 128; p++) begin
			model_reg[p] = '0;
			busy[p]      = 1'b0;
			refcnt[p]    = 0;
		end
		repeat (10) @(posedge CLK);
		#1;
		rst_n = 1'b1;
		tick();
		// reset levels
		if (res_empty !== 1'b1 || disp_full !== 1'b0 || link_valid !== 1'b0) begin
			tb_errors++;
			$display("** Error at %0t: after reset res_empty %b disp_full %b link_valid %b",
				$time, res_empty, disp_full, link_valid);
		end
		// give every non-x0 slot a known value
		for (int p = 4; p < 128; p++) begin
			write_back(7'(p));
		end

		// random mix with random commit pops and ilp
		pop_on   = 1'b1;
		ilp_mode = 2;
		for (int i = 0; i < 80; i++) begin
			dispatch(bru_op_e'($urandom_range(7)), -1);
			if ($urandom_range(3) == 0) begin
				tick();
			end
		end
		drain();

		// dependent branch waits for the link write
		ilp_mode = 0;
		dispatch(BRU_JAL, -1);
		dispatch(BRU_BEQ, int'(last_rd));
		dispatch(BRU_JALR, int'(last_rd));
		drain();

		// jumps go while ilp is low and branches hold
		ilp_mode = 1;
		dispatch(BRU_JALR, -1);
		drain();
		dispatch(BRU_BLT, -1);
		for (int i = 0; i < 8; i++) begin
			tick();
			if (!res_empty) begin
				tb_errors++;
				$display("** Error at %0t: branch resolved while ilp_ready was low", $time);
			end
		end
		ilp_mode = 2;
		drain();

		// back-pressure with the commit side stalled
		pop_on   = 1'b0;
		ilp_mode = 0;
		n = 0;
		while (!disp_full && n < 40) begin
			dispatch(bru_op_e'($urandom_range(7)), -1);
			n++;
		end
		if (!disp_full) begin
			tb_errors++;
			$display("issue queue never filled while the commit side was stalled");
		end
		repeat (5) tick();
		drain();

		// flush with work queued on both sides
		pop_on = 1'b0;
		for (int i = 0; i < 6; i++) begin
			dispatch(bru_op_e'($urandom_range(7)), -1);
		end
		tick();
		flush = 1'b1;
		tick();
		src_q.delete();
		for (int p = 0; p < 128; p++) begin
			refcnt[p] = 0;
		end
		if (res_empty !== 1'b1 || disp_full !== 1'b0) begin
			tb_errors++;
			$display("** Error at %0t: after flush res_empty %b disp_full %b",
				$time, res_empty, disp_full);
		end
		// slots left allocated by dropped jumps get a value
		for (int p = 4; p < 128; p++) begin
			if (busy[p]) begin
				write_back(7'(p));
			end
		end
		pop_on   = 1'b1;
		ilp_mode = 2;
		for (int i = 0; i < 20; i++) begin
			dispatch(bru_op_e'($urandom_range(7)), -1);
		end
		drain();
		repeat (4) tick();

		if (res_pending != 0 || link_pending != 0) begin
			tb_errors++;
			$display("expected records were left unchecked at the end");
		end
		$display("errors: %0d mismatches, %0d other, %0d testbench, %0d timeouts",
			mismatches, other_errors, tb_errors, timeouts);
		if (mismatches + other_errors + tb_errors + timeouts == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: bru_top.f
+incdir+hdl
hdl/bru_pkg.sv
hdl/bru_fifo.sv
hdl/bru_wb_log.sv
hdl/bru_issue.sv
hdl/bru_execute.sv
hdl/bru_top.sv
tests/bru_assertions.sv
tests/bru_checker.sv
tests/bru_tb.sv

// File: run.sh
#!/bin/sh
# build and run the branch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f bru_top.f --top-module bru_tb -o bru_sim
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi

out=$(./obj_dir/bru_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with a nonzero status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
	exit 0
else
	exit 1
fi
